// File: include/sd_consts.svh
// SD card SPI init constants
// SCLK divider, dummy byte count and response poll limit
`ifndef SD_CONSTS_SVH
`define SD_CONSTS_SVH

// clk cycles per SCLK half period
`define SD_SCLK_HALF 2

// 0xFF bytes sent with chip select high before CMD0
// Gives the card at least 74 clocks to power up
`define SD_DUMMY_BYTES 10

// Poll reads that may return 0xFF before a timeout
`define SD_POLL_LIMIT 8

`endif

// File: design/sd_pkg.sv
// Shared types for the SD SPI init design
// Byte and bus typedefs, request struct, state enums
`default_nettype none

package sd_pkg;

  // One byte on the SPI line
  typedef logic [7:0] byte_t;

  // Bit 0 byte transfer, bit 1 chip select write
  typedef logic [1:0] bus_sel_t;

  // Request from the sequencer to the SPI port
  // dat[7:0] is the byte, dat[8] the chip select value
  typedef struct packed {
    logic [8:0] dat;
    logic       we;
    bus_sel_t   sel;
    logic       stb;
  } bus_req_t;

  // Init sequencer states
  typedef enum logic [2:0] {
    SEQ_IDLE, SEQ_DUMMY, SEQ_CS_LOW, SEQ_GAP, SEQ_CMD, SEQ_POLL, SEQ_DONE, SEQ_TOUT
  } seq_state_e;

  // Byte shifter states
  typedef enum logic [1:0] {SPI_IDLE, SPI_LOW, SPI_HIGH, SPI_FINISH} spi_state_e;

endpackage

`default_nettype wire

// File: design/spi_byte_shifter.sv
// SPI mode 0 byte engine
// One byte out on MOSI and one byte in from MISO, MSB first
`timescale 1ns/1ns
`default_nettype none

`include "sd_consts.svh"

module spi_byte_shifter (
  input  logic          clk,
  input  logic          rst,
  input  logic          start_i,
  input  sd_pkg::byte_t tx_i,
  input  logic          miso_i,
  output logic          sclk_o,
  output logic          mosi_o,
  output logic          done_o,
  output sd_pkg::byte_t rx_o
);

  localparam int HW = $clog2(`SD_SCLK_HALF + 1);
  localparam logic [HW-1:0] HALF_LAST = HW'(`SD_SCLK_HALF - 1);

  sd_pkg::spi_state_e state;
  logic [HW-1:0]      half_cnt;
  logic [2:0]         bit_cnt;
  sd_pkg::byte_t      tx_sr;
  sd_pkg::byte_t      rx_sr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= sd_pkg::SPI_IDLE;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk_o   <= 1'b0;
      tx_sr    <= 8'hff;
    end else begin
      case (state)
        sd_pkg::SPI_IDLE: begin
          if (start_i) begin
            tx_sr    <= tx_i;
            half_cnt <= '0;
            bit_cnt  <= '0;
            state    <= sd_pkg::SPI_LOW;
          end
        end
        sd_pkg::SPI_LOW: begin
          if (half_cnt == HALF_LAST) begin
            half_cnt <= '0;
            sclk_o   <= 1'b1;
            state    <= sd_pkg::SPI_HIGH;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        sd_pkg::SPI_HIGH: begin
          if (half_cnt == HALF_LAST) begin
            half_cnt <= '0;
            sclk_o   <= 1'b0;
            if (bit_cnt == 3'd7) begin
              state <= sd_pkg::SPI_FINISH;
            end else begin
              // Next bit goes out while SCLK is low
              bit_cnt <= bit_cnt + 3'd1;
              tx_sr   <= {tx_sr[6:0], 1'b1};
              state   <= sd_pkg::SPI_LOW;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        sd_pkg::SPI_FINISH: begin
          // MOSI idles high between bytes
          tx_sr <= 8'hff;
          state <= sd_pkg::SPI_IDLE;
        end
        default: state <= sd_pkg::SPI_IDLE;
      endcase
    end
  end

  // Sample MISO in the cycle SCLK rises
  always_ff @(posedge clk) begin
    if (state == sd_pkg::SPI_LOW && half_cnt == HALF_LAST) begin
      rx_sr <= {rx_sr[6:0], miso_i};
    end
  end

  assign mosi_o = tx_sr[7];
  assign done_o = (state == sd_pkg::SPI_FINISH);
  assign rx_o   = rx_sr;

endmodule

`default_nettype wire

// File: design/sdspi.sv
// SPI port bus slave
// Decodes requests into chip select writes and byte transfers
`timescale 1ns/1ns
`default_nettype none

module sdspi (
  input  logic             clk,
  input  logic             rst,
  input  sd_pkg::bus_req_t req_i,
  output logic             ack_o,
  output sd_pkg::byte_t    rdata_o,
  output logic             sclk_o,
  output logic             mosi_o,
  input  logic             miso_i,
  output logic             ss_o
);

  logic          accept;
  logic          busy;
  logic          shift_start;
  logic          shift_done;
  sd_pkg::byte_t shift_rx;

  // The ack cycle still shows the old request, so skip it
  assign accept      = req_i.stb && !busy && !ack_o;
  assign shift_start = accept && req_i.sel[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      ss_o  <= 1'b1;
      busy  <= 1'b0;
      ack_o <= 1'b0;
    end else begin
      ack_o <= 1'b0;
      if (accept) begin
        // dat bit 8 set drives chip select low
        if (req_i.sel[1]) begin
          ss_o <= ~req_i.dat[8];
        end
        if (req_i.sel[0]) begin
          busy <= 1'b1;
        end else begin
          ack_o <= 1'b1;
        end
      end
      if (busy && shift_done) begin
        busy  <= 1'b0;
        ack_o <= 1'b1;
      end
    end
  end

  // Received byte is valid together with ack
  always_ff @(posedge clk) begin
    if (shift_done) begin
      rdata_o <= shift_rx;
    end
  end

  spi_byte_shifter u_shifter (
    .clk     (clk),
    .rst     (rst),
    .start_i (shift_start),
    .tx_i    (req_i.dat[7:0]),
    .miso_i  (miso_i),
    .sclk_o  (sclk_o),
    .mosi_o  (mosi_o),
    .done_o  (shift_done),
    .rx_o    (shift_rx)
  );

endmodule

`default_nettype wire

// File: design/sd_init_seq.sv
// SD card SPI mode init sequencer
// Dummy clocks, CMD0, response polling and trailing byte
`timescale 1ns/1ns
`default_nettype none

`include "sd_consts.svh"

module sd_init_seq (
  input  logic             clk,
  input  logic             rst,
  input  logic             start_i,
  output sd_pkg::bus_req_t req_o,
  input  logic             ack_i,
  input  sd_pkg::byte_t    rdata_i,
  output sd_pkg::byte_t    resp_o,
  output logic             done_o,
  output logic             timeout_o
);

  localparam logic [7:0] DUMMY_LAST = 8'(`SD_DUMMY_BYTES - 1);
  localparam logic [7:0] POLL_LAST  = 8'(`SD_POLL_LIMIT - 1);

  sd_pkg::seq_state_e state;
  // Dummy count, CMD0 index or poll count depending on state
  logic [7:0]         cnt;

  function automatic sd_pkg::bus_req_t make_req(input logic [8:0]       dat,
                                                input logic             we,
                                                input sd_pkg::bus_sel_t sel);
    sd_pkg::bus_req_t r;
    r.dat = dat;
    r.we  = we;
    r.sel = sel;
    r.stb = 1'b1;
    return r;
  endfunction

  // CMD0 frame 40 00 00 00 00 95
  function automatic sd_pkg::byte_t cmd0_byte(input logic [2:0] idx);
    sd_pkg::byte_t b;
    case (idx)
      3'd0:    b = 8'h40;
      3'd5:    b = 8'h95;
      default: b = 8'h00;
    endcase
    return b;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= sd_pkg::SEQ_IDLE;
      cnt       <= '0;
      req_o     <= '0;
      done_o    <= 1'b0;
      timeout_o <= 1'b0;
    end else begin
      case (state)
        sd_pkg::SEQ_IDLE: begin
          req_o <= make_req(9'h0ff, 1'b1, 2'b01);
          cnt   <= '0;
          state <= sd_pkg::SEQ_DUMMY;
        end
        sd_pkg::SEQ_DUMMY: begin
          // Same 0xFF request stays on the bus until the last one
          if (ack_i) begin
            if (cnt == DUMMY_LAST) begin
              req_o <= make_req(9'h100, 1'b1, 2'b10);
              state <= sd_pkg::SEQ_CS_LOW;
            end else begin
              cnt <= cnt + 8'd1;
            end
          end
        end
        sd_pkg::SEQ_CS_LOW: begin
          if (ack_i) begin
            req_o <= make_req(9'h0ff, 1'b1, 2'b01);
            state <= sd_pkg::SEQ_GAP;
          end
        end
        sd_pkg::SEQ_GAP: begin
          if (ack_i) begin
            req_o <= make_req({1'b0, cmd0_byte(3'd0)}, 1'b1, 2'b01);
            cnt   <= '0;
            state <= sd_pkg::SEQ_CMD;
          end
        end
        sd_pkg::SEQ_CMD: begin
          if (ack_i) begin
            if (cnt == 8'd5) begin
              req_o <= make_req(9'h0ff, 1'b0, 2'b01);
              cnt   <= '0;
              state <= sd_pkg::SEQ_POLL;
            end else begin
              req_o <= make_req({1'b0, cmd0_byte(cnt[2:0] + 3'd1)}, 1'b1, 2'b01);
              cnt   <= cnt + 8'd1;
            end
          end
        end
        sd_pkg::SEQ_POLL: begin
          if (ack_i) begin
            // Finish with chip select high plus one 0xFF in a single request
            if (rdata_i != 8'hff) begin
              resp_o <= rdata_i;
              req_o  <= make_req(9'h0ff, 1'b1, 2'b11);
              state  <= sd_pkg::SEQ_DONE;
            end else if (cnt == POLL_LAST) begin
              req_o <= make_req(9'h0ff, 1'b1, 2'b11);
              state <= sd_pkg::SEQ_TOUT;
            end else begin
              cnt <= cnt + 8'd1;
            end
          end
        end
        sd_pkg::SEQ_DONE, sd_pkg::SEQ_TOUT: begin
          if (req_o.stb) begin
            // Flag rises once the trailing byte is out
            if (ack_i) begin
              req_o.stb <= 1'b0;
              done_o    <= (state == sd_pkg::SEQ_DONE);
              timeout_o <= (state == sd_pkg::SEQ_TOUT);
            end
          end else if (start_i) begin
            done_o    <= 1'b0;
            timeout_o <= 1'b0;
            state     <= sd_pkg::SEQ_IDLE;
          end
        end
        default: state <= sd_pkg::SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/sd_init_top.sv
// SD card SPI init top level
// Sequencer and SPI port wired to the card pads
`timescale 1ns/1ns
`default_nettype none

module sd_init_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          start_i,
  input  logic          sd_miso_i,
  output logic          sd_sclk_o,
  output logic          sd_mosi_o,
  output logic          sd_ss_o,
  output sd_pkg::byte_t resp_o,
  output logic          done_o,
  output logic          timeout_o
);

  sd_pkg::bus_req_t req;
  logic             ack;
  sd_pkg::byte_t    rdata;

  sd_init_seq u_seq (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start_i),
    .req_o     (req),
    .ack_i     (ack),
    .rdata_i   (rdata),
    .resp_o    (resp_o),
    .done_o    (done_o),
    .timeout_o (timeout_o)
  );

  sdspi u_spi (
    .clk     (clk),
    .rst     (rst),
    .req_i   (req),
    .ack_o   (ack),
    .rdata_o (rdata),
    .sclk_o  (sd_sclk_o),
    .mosi_o  (sd_mosi_o),
    .miso_i  (sd_miso_i),
    .ss_o    (sd_ss_o)
  );

endmodule

`default_nettype wire

// File: sim/sd_card_model.sv
// Behavioral SD card in SPI mode
// Captures MOSI bytes and answers CMD0 with R1 after a set number of polls
`timescale 1ns/1ns
`default_nettype none

module sd_card_model (
  input  logic          sclk_i,
  input  logic          mosi_i,
  input  logic          ss_i,
  output logic          miso_o,
  input  int            delay_i,
  input  sd_pkg::byte_t r1_i,
  output sd_pkg::byte_t cap_byte_o,
  output logic          cap_ss_o,
  output int            cap_cnt_o
);

  localparam logic [47:0] CMD0_FRAME = 48'h40_0000_0000_95;

  sd_pkg::byte_t in_sr     = 8'hff;
  sd_pkg::byte_t out_sr    = 8'hff;
  sd_pkg::byte_t next_out  = 8'hff;
  sd_pkg::byte_t last_byte = 8'hff;
  logic          last_ss   = 1'b1;
  // Last six bytes seen with chip select low
  logic [47:0]   hist      = '0;
  logic          armed     = 1'b0;
  int            bit_cnt   = 0;
  int            poll_idx  = 0;
  int            byte_cnt  = 0;

  // MISO floats high while deselected
  assign miso_o     = ss_i ? 1'b1 : out_sr[7];
  assign cap_byte_o = last_byte;
  assign cap_ss_o   = last_ss;
  assign cap_cnt_o  = byte_cnt;

  // Pick the byte that goes out during the next transfer
  task automatic update_response();
    if (ss_i) begin
      armed = 1'b0;
      hist  = '0;
    end else if (armed) begin
      poll_idx = poll_idx + 1;
      if (poll_idx > delay_i) begin
        armed = 1'b0;
      end
    end else begin
      hist = {hist[39:0], in_sr};
      if (hist == CMD0_FRAME) begin
        armed    = 1'b1;
        poll_idx = 0;
        hist     = '0;
      end
    end
    next_out = (armed && poll_idx == delay_i) ? r1_i : 8'hff;
  endtask

  always @(posedge sclk_i or negedge sclk_i) begin
    if (sclk_i) begin
      in_sr   = {in_sr[6:0], mosi_i};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8) begin
        bit_cnt   = 0;
        last_byte = in_sr;
        last_ss   = ss_i;
        byte_cnt  = byte_cnt + 1;
        update_response();
      end
    end else if (bit_cnt == 0) begin
      // Load the next reply at the byte boundary
      out_sr = next_out;
    end else begin
      out_sr = {out_sr[6:0], 1'b1};
    end
  end

endmodule

`default_nettype wire

// File: sim/sd_init_checker.sv
// Checker for the SD SPI init run
// Reference MOSI stream and comparison of bytes, chip select and results
`timescale 1ns/1ns
`default_nettype none

`include "sd_consts.svh"

module sd_init_checker (
  input  logic          clk,
  input  logic          rst,
  input  logic          sclk_i,
  input  logic          ss_i,
  input  sd_pkg::byte_t resp_i,
  input  logic          done_i,
  input  logic          timeout_i,
  input  sd_pkg::byte_t cap_byte_i,
  input  logic          cap_ss_i,
  input  int            cap_cnt_i,
  input  int            delay_i,
  input  sd_pkg::byte_t r1_i,
  output int            runs_o,
  output int            errors_o,
  output int            checks_o
);

  // Each entry is {chip select, byte}
  logic [8:0] got[$];
  int         seen_cnt = 0;
  int         runs     = 0;
  int         errors   = 0;
  int         checks   = 0;
  logic       flag_q   = 1'b0;
  logic       rst_q    = 1'b1;

  assign runs_o   = runs;
  assign errors_o = errors;
  assign checks_o = checks;

  function automatic int poll_count(input int delay);
    return (delay < `SD_POLL_LIMIT) ? delay + 1 : `SD_POLL_LIMIT;
  endfunction

  // Dummies, gap, CMD0, polls, trailing byte
  function automatic int stream_length(input int delay);
    return `SD_DUMMY_BYTES + 1 + 6 + poll_count(delay) + 1;
  endfunction

  function automatic logic [8:0] stream_entry(input int delay, input int idx);
    logic [47:0] cmd0;
    logic [8:0]  e;
    int          k;
    cmd0 = 48'h40_0000_0000_95;
    k    = idx - `SD_DUMMY_BYTES - 1;
    if (idx < `SD_DUMMY_BYTES) begin
      e = {1'b1, 8'hff};
    end else if (idx == `SD_DUMMY_BYTES) begin
      e = {1'b0, 8'hff};
    end else if (k < 6) begin
      e = {1'b0, 8'(cmd0 >> (8 * (5 - k)))};
    end else if (k < 6 + poll_count(delay)) begin
      e = {1'b0, 8'hff};
    end else begin
      e = {1'b1, 8'hff};
    end
    return e;
  endfunction

  task automatic compare(input string what, input logic [31:0] got_v,
                         input logic [31:0] exp_v);
    checks = checks + 1;
    if (got_v !== exp_v) begin
      errors = errors + 1;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", what, got_v, exp_v,
               $time);
    end
  endtask

  task automatic check_run();
    logic [8:0] exp_e;
    int         n;
    int         i;
    n = stream_length(delay_i);
    compare("sd_mosi_o byte count", 32'(got.size()), 32'(n));
    for (i = 0; i < n && i < got.size(); i++) begin
      exp_e = stream_entry(delay_i, i);
      compare($sformatf("sd_mosi_o byte %0d", i), 32'(got[i][7:0]), 32'(exp_e[7:0]));
      compare($sformatf("sd_ss_o at byte %0d", i), 32'(got[i][8]), 32'(exp_e[8]));
    end
    compare("sd_ss_o at end of run", 32'(ss_i), 32'd1);
    if (delay_i < `SD_POLL_LIMIT) begin
      compare("done_o", 32'(done_i), 32'd1);
      compare("timeout_o", 32'(timeout_i), 32'd0);
      compare("resp_o", 32'(resp_i), 32'(r1_i));
    end else begin
      compare("done_o", 32'(done_i), 32'd0);
      compare("timeout_o", 32'(timeout_i), 32'd1);
    end
    runs = runs + 1;
    $display("Run %0d ended after %0d bytes on MOSI", runs, got.size());
    got.delete();
  endtask

  always @(negedge clk) begin
    if (rst) begin
      got.delete();
      seen_cnt = cap_cnt_i;
      flag_q   = 1'b0;
    end else begin
      if (rst_q) begin
        compare("sd_sclk_o after reset", 32'(sclk_i), 32'd0);
        compare("sd_ss_o after reset", 32'(ss_i), 32'd1);
        compare("done_o after reset", 32'(done_i), 32'd0);
        compare("timeout_o after reset", 32'(timeout_i), 32'd0);
      end
      if (cap_cnt_i != seen_cnt) begin
        got.push_back({cap_ss_i, cap_byte_i});
        seen_cnt = cap_cnt_i;
      end
      if ((done_i || timeout_i) && !flag_q) begin
        check_run();
      end
      flag_q = done_i || timeout_i;
    end
    rst_q = rst;
  end

endmodule

`default_nettype wire

// File: sim/tb_sd_init.sv
// SD SPI init testbench top
// Clock, reset, randomized card runs, watchdog and final report
`timescale 1ns/1ns
`default_nettype none

`include "sd_consts.svh"

module tb_sd_init;

  localparam int RUNS        = 6;
  localparam int CLK_NS      = 4;
  localparam int WORST_BYTES = `SD_DUMMY_BYTES + 1 + 6 + `SD_POLL_LIMIT + 1;
  // Worst case over all runs, doubled, plus reset
  localparam int LIMIT_NS    = RUNS * WORST_BYTES * 16 * `SD_SCLK_HALF * CLK_NS * 2
                               + 8 * CLK_NS;

  logic          clk;
  logic          rst;
  logic          start;
  logic          miso;
  logic          sclk;
  logic          mosi;
  logic          ss;
  sd_pkg::byte_t resp;
  logic          done;
  logic          tout;
  int            delay;
  sd_pkg::byte_t r1;
  logic [31:0]   rng;
  sd_pkg::byte_t cap_byte;
  logic          cap_ss;
  int            cap_cnt;
  int            runs;
  int            errors;
  int            checks;

  sd_init_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start),
    .sd_miso_i (miso),
    .sd_sclk_o (sclk),
    .sd_mosi_o (mosi),
    .sd_ss_o   (ss),
    .resp_o    (resp),
    .done_o    (done),
    .timeout_o (tout)
  );

  sd_card_model card (
    .sclk_i     (sclk),
    .mosi_i     (mosi),
    .ss_i       (ss),
    .miso_o     (miso),
    .delay_i    (delay),
    .r1_i       (r1),
    .cap_byte_o (cap_byte),
    .cap_ss_o   (cap_ss),
    .cap_cnt_o  (cap_cnt)
  );

  sd_init_checker run_checker (
    .clk        (clk),
    .rst        (rst),
    .sclk_i     (sclk),
    .ss_i       (ss),
    .resp_i     (resp),
    .done_i     (done),
    .timeout_i  (tout),
    .cap_byte_i (cap_byte),
    .cap_ss_i   (cap_ss),
    .cap_cnt_i  (cap_cnt),
    .delay_i    (delay),
    .r1_i       (r1),
    .runs_o     (runs),
    .errors_o   (errors),
    .checks_o   (checks)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Delays at or above the poll limit end in a timeout
  task automatic pick_run(input int idx);
    rng   = next_random(rng);
    delay = int'(rng % 32'd11);
    rng   = next_random(rng);
    r1    = rng[7:0] & 8'h7f;
    $display("Run %0d: card delay %0d polls, R1 0x%02h", idx + 1, delay, r1);
  endtask

  task automatic wait_run(input int n);
    while (runs < n) begin
      @(posedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    int run;
    rst   = 1'b1;
    start = 1'b0;
    rng   = 32'hff29;
    pick_run(0);
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    // First run starts on its own after reset
    wait_run(1);
    for (run = 1; run < RUNS; run++) begin
      #1;
      pick_run(run);
      start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
      wait_run(run + 1);
    end
    $display("Runs: %0d, checks: %0d, errors: %0d", runs, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(LIMIT_NS);
    $display("Watchdog expired after %0d ns with %0d of %0d runs finished",
             LIMIT_NS, runs, RUNS);
    $display("Runs: %0d, checks: %0d, errors: %0d", runs, checks, errors);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: sd_init_top.f
+incdir+include
design/sd_pkg.sv
design/spi_byte_shifter.sv
design/sdspi.sv
design/sd_init_seq.sv
design/sd_init_top.sv
sim/sd_card_model.sv
sim/sd_init_checker.sv
sim/tb_sd_init.sv

// File: Makefile
# Verilator flow for the SD card SPI init testbench
# make lint, make sim, make clean

FLIST = sd_init_top.f
TOP   = tb_sd_init

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then \
	  echo "Simulation reported a failure, see sim.log"; \
	  exit 1; \
	fi
	@if ! grep -q "TEST PASS" sim.log; then \
	  echo "Simulation ended without a pass result, see sim.log"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
